/* include/scroll_settings.svh */
`ifndef SCROLL_SETTINGS_SVH
`define SCROLL_SETTINGS_SVH

//////////////////////////////
// memory side address widths

`define SCROLL_VRAM_AW 17   // 16-bit words
`define SCROLL_ROM_AW 20    // 32-bit words
`define SCROLL_BUF_AW 9     // one 512 pixel line

//////////////////////////////
// line geometry

// last buffer address of the visible part of a line
`define SCROLL_LINE_LAST 447

//////////////////////////////
// bank mapper

`define SCROLL_NUM_GAMES 4  // rows in the code limit table

`endif

/* source/scroll_types_pkg.sv */
`default_nettype none

package scroll_types_pkg;

    // tile size, one hot as in the layer registers
    typedef enum logic [2:0] {
        size_8  = 3'b001,
        size_16 = 3'b010,
        size_32 = 3'b100
    } tile_size_t;

    typedef logic [15:0] tile_code_t;  // first VRAM word of a tile
    typedef logic [3:0]  colour_t;     // 4bpp colour index
    typedef logic [2:0]  layer_t;      // mapper layer, 1 to 3

    // second VRAM word of a tile
    typedef struct packed {
        logic [6:0] spare;
        logic [1:0] group;
        logic       vflip;
        logic       hflip;
        logic [4:0] pal;
    } tile_attr_t;

    // line buffer entry
    typedef struct packed {
        logic [1:0] group;
        logic [4:0] pal;
        colour_t    colour;
    } pixel_t;

    typedef struct packed {
        tile_size_t  size;
        logic [15:0] vram_base;
        logic [15:0] hpos;
        logic [15:0] vpos;
        logic        row_en;    // per line scroll from VRAM
        logic [16:0] vram_row;
    } layer_ctrl_t;

    typedef struct packed {
        logic [5:0]  game;
        logic [15:0] bank_offset;  // one nibble per layer
        logic [15:0] bank_mask;    // same layout
    } bank_ctrl_t;

endpackage

`default_nettype wire

/* source/bus_types_pkg.sv */
`default_nettype none

`include "scroll_settings.svh"

package bus_types_pkg;

    typedef logic [`SCROLL_VRAM_AW-1:0] vram_addr_t;
    typedef logic [`SCROLL_ROM_AW-1:0]  rom_addr_t;
    typedef logic [`SCROLL_BUF_AW-1:0]  buf_addr_t;

    //////////////////////////////
    // requests, held until ok

    typedef struct packed {
        vram_addr_t addr;
        logic       cs;
    } vram_req_t;

    typedef struct packed {
        rom_addr_t addr;
        logic      half;   // 32-bit half of a 16 pixel row
        logic      cs;
    } rom_req_t;

    //////////////////////////////
    // line buffer write port

    typedef struct packed {
        buf_addr_t                addr;
        scroll_types_pkg::pixel_t data;
        logic                     wr;
    } buf_write_t;

endpackage

`default_nettype wire

/* source/gfx_bank_mapper.sv */
`timescale 1ns/100ps
`default_nettype none

`include "scroll_settings.svh"

module gfx_bank_mapper (
    input  wire                                clk,
    input  wire                                rst,
    input  wire scroll_types_pkg::bank_ctrl_t  bank,
    input  wire                                enable,
    input  wire scroll_types_pkg::layer_t      layer,
    input  wire logic [9:0]                    cin,
    output logic [3:0]                         offset,
    output logic [3:0]                         mask,
    output logic                               unmapped
);

    localparam int GAME_W = $clog2(`SCROLL_NUM_GAMES);

    // highest mapped code per game, columns are layers 1 to 3
    localparam logic [9:0] CODE_LIMIT [`SCROLL_NUM_GAMES][1:3] = '{
        '{10'h3ff, 10'h3ff, 10'h3ff},
        '{10'h1ff, 10'h2ff, 10'h0ff},
        '{10'h0ff, 10'h17f, 10'h07f},
        '{10'h2ff, 10'h1ff, 10'h13f}
    };

    logic       game_ok;
    logic       layer_ok;
    logic [1:0] nib;     // nibble of the bank registers
    logic [9:0] limit;

    //////////////////////////////
    // table lookup

    always_comb begin
        game_ok  = bank.game < 6'(`SCROLL_NUM_GAMES);
        layer_ok = (layer != 3'd0) && (layer <= 3'd3);
        nib      = layer[1:0] - 2'd1;   // layer 1 uses the low nibble
        limit    = '0;
        if (game_ok && layer_ok) begin
            limit = CODE_LIMIT[bank.game[GAME_W-1:0]][layer[1:0]];
        end
    end

    //////////////////////////////
    // registered outputs

    // follows cin while enabled, holds the last code afterwards
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            offset   <= '0;
            mask     <= '0;
            unmapped <= 1'b0;
        end else if (enable) begin
            offset   <= bank.bank_offset[{nib, 2'b00} +: 4];
            mask     <= bank.bank_mask[{nib, 2'b00} +: 4];
            unmapped <= !(game_ok && layer_ok) || (cin > limit);
        end
    end

endmodule

`default_nettype wire

/* source/line_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module line_buffer (
    input  wire                               clk,
    input  wire bus_types_pkg::buf_write_t    wr_port,
    input  wire bus_types_pkg::buf_addr_t     rd_addr,
    output scroll_types_pkg::pixel_t          rd_pixel
);

    localparam int DEPTH = 2 ** $bits(bus_types_pkg::buf_addr_t);

    scroll_types_pkg::pixel_t mem [DEPTH];

    //////////////////////////////
    // write side, from the fetcher

    always_ff @(posedge clk) begin
        if (wr_port.wr) begin
            mem[wr_port.addr] <= wr_port.data;
        end
    end

    //////////////////////////////
    // read side

    // one cycle from address to pixel
    always_ff @(posedge clk) begin
        rd_pixel <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* source/tilemap_fetcher.sv */
`timescale 1ns/100ps
`default_nettype none

`include "scroll_settings.svh"

module tilemap_fetcher (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire scroll_types_pkg::layer_ctrl_t  ctrl,
    input  wire logic [8:0]                     vrender,
    input  wire                                 start,
    input  wire                                 stop,
    output logic                                done,
    output bus_types_pkg::vram_req_t            vram,
    input  wire logic [15:0]                    vram_data,
    input  wire                                 vram_ok,
    output bus_types_pkg::rom_req_t             rom,
    input  wire logic [31:0]                    rom_data,
    input  wire                                 rom_ok,
    output logic                                map_enable,
    output scroll_types_pkg::layer_t            map_layer,
    input  wire logic [3:0]                     map_offset,
    input  wire logic [3:0]                     map_mask,
    input  wire                                 map_unmapped,
    output bus_types_pkg::buf_write_t           lbuf
);

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_ROW,
        ST_CODE_REQ,
        ST_CODE,
        ST_ATTR_REQ,
        ST_ATTR,
        ST_ROM_REQ,
        ST_ROM_WAIT,
        ST_DRAW,
        ST_ROM_NEXT
    } state_t;

    state_t                       st;
    logic [10:0]                  vn;        // line inside the tilemap
    logic [10:0]                  hn;        // column of the current tile
    scroll_types_pkg::tile_code_t code;
    scroll_types_pkg::tile_attr_t attr;
    logic [31:0]                  pxl;       // planar word being drawn
    logic [2:0]                   pix_cnt;
    logic [1:0]                   part;      // 8 pixel part of the tile row
    logic [1:0]                   last_part;
    logic [11:0]                  scan;
    logic [10:0]                  tile_w;
    bus_types_pkg::vram_addr_t    tile_addr;
    bus_types_pkg::rom_addr_t     rom_pre;
    bus_types_pkg::rom_addr_t     rom_masked;
    bus_types_pkg::rom_addr_t     rom_next;

    // scroll value aligned down to the tile grid
    function automatic logic [10:0] align(
        input logic [15:0]                  h,
        input scroll_types_pkg::tile_size_t sz
    );
        case (sz)
            scroll_types_pkg::size_8:  align = {h[10:3], 3'b0};
            scroll_types_pkg::size_16: align = {h[10:4], 4'b0};
            default:                   align = {h[10:5], 5'b0};
        endcase
    endfunction

    // fine scroll pixels wrap into the hidden end of the buffer
    function automatic bus_types_pkg::buf_addr_t start_addr(
        input logic [15:0]                  h,
        input scroll_types_pkg::tile_size_t sz
    );
        case (sz)
            scroll_types_pkg::size_8:  start_addr = 9'h1ff - {6'b0, h[2:0]};
            scroll_types_pkg::size_16: start_addr = 9'h1ff - {5'b0, h[3:0]};
            default:                   start_addr = 9'h1ff - {4'b0, h[4:0]};
        endcase
    endfunction

    function automatic scroll_types_pkg::colour_t colour(
        input logic [31:0] w,
        input logic        flip
    );
        colour = flip ? {w[24], w[16], w[8], w[0]} : {w[31], w[23], w[15], w[7]};
    endfunction

    //////////////////////////////
    // addresses per tile size

    always_comb begin
        case (ctrl.size)
            scroll_types_pkg::size_8: begin
                scan      = {vn[8], hn[8:3], vn[7:3]};
                map_layer = 3'd1;
                tile_w    = 11'd8;
                last_part = 2'd0;
                rom_pre   = {1'b0, code, vn[2:0] ^ {3{attr.vflip}}};
            end
            scroll_types_pkg::size_16: begin
                scan      = {vn[9:8], hn[9:4], vn[7:4]};
                map_layer = 3'd2;
                tile_w    = 11'd16;
                last_part = 2'd1;
                rom_pre   = {code, vn[3:0] ^ {4{attr.vflip}}};
            end
            default: begin
                scan      = {vn[10:8], hn[10:5], vn[7:5]};
                map_layer = 3'd3;
                tile_w    = 11'd32;
                last_part = 2'd3;
                rom_pre   = {code[13:0], vn[4:0] ^ {5{attr.vflip}}, attr.hflip};
            end
        endcase
        rom_masked = rom_pre & {map_mask, 16'hffff};
        rom_next   = rom_masked | {map_offset, 16'h0};
        tile_addr  = {ctrl.vram_base[9:1], 8'd0} + {4'd0, scan, 1'b0};
    end

    //////////////////////////////
    // scanline FSM

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st         <= ST_IDLE;
            done       <= 1'b0;
            vram       <= '0;
            rom        <= '0;
            lbuf       <= '0;
            map_enable <= 1'b0;
            vn         <= '0;
            hn         <= '0;
            code       <= '0;
            attr       <= '0;
            pxl        <= '0;
            pix_cnt    <= '0;
            part       <= '0;
        end else begin
            done    <= 1'b0;
            lbuf.wr <= 1'b0;
            case (st)
                ST_IDLE: begin
                    vram.cs    <= 1'b0;
                    rom.cs     <= 1'b0;
                    map_enable <= 1'b0;
                    vn         <= ctrl.vpos[10:0] + {2'b0, vrender};
                    hn         <= align(ctrl.hpos, ctrl.size);
                    lbuf.addr  <= start_addr(ctrl.hpos, ctrl.size);
                    if (start) begin
                        if (ctrl.row_en) begin
                            vram.addr <= ctrl.vram_row;
                            vram.cs   <= 1'b1;
                            st        <= ST_ROW;
                        end else begin
                            st <= ST_CODE_REQ;
                        end
                    end
                end
                ST_ROW: if (vram_ok) begin   // scroll word replaces hpos
                    hn        <= align(vram_data, ctrl.size);
                    lbuf.addr <= start_addr(vram_data, ctrl.size);
                    vram.cs   <= 1'b0;
                    st        <= ST_CODE_REQ;
                end
                ST_CODE_REQ: begin
                    vram.addr  <= tile_addr;
                    vram.cs    <= 1'b1;
                    map_enable <= 1'b1;
                    st         <= ST_CODE;
                end
                ST_CODE: if (vram_ok) begin
                    code         <= vram_data;
                    map_enable   <= 1'b0;   // mapper keeps this code
                    vram.cs      <= 1'b0;
                    vram.addr[0] <= 1'b1;   // attribute word
                    st           <= ST_ATTR_REQ;
                end
                ST_ATTR_REQ: begin
                    vram.cs <= 1'b1;
                    st      <= ST_ATTR;
                end
                ST_ATTR: if (vram_ok) begin
                    attr    <= vram_data;
                    vram.cs <= 1'b0;
                    st      <= ST_ROM_REQ;
                end
                ST_ROM_REQ: begin
                    rom.addr <= rom_next;
                    rom.half <= attr.hflip;   // flipped rows start on the right half
                    rom.cs   <= 1'b1;
                    part     <= 2'd0;
                    hn       <= hn + tile_w;
                    st       <= ST_ROM_WAIT;
                end
                ST_ROM_WAIT: if (rom_ok) begin
                    pxl     <= rom_data;
                    rom.cs  <= 1'b0;
                    pix_cnt <= 3'd0;
                    st      <= ST_DRAW;
                end
                ST_DRAW: begin
                    lbuf.wr   <= 1'b1;
                    lbuf.addr <= lbuf.addr + 1'b1;
                    lbuf.data <= scroll_types_pkg::pixel_t'{
                        group:  attr.group,
                        pal:    attr.pal,
                        colour: map_unmapped ? 4'hf : colour(pxl, attr.hflip)
                    };
                    pxl     <= attr.hflip ? pxl >> 1 : pxl << 1;
                    pix_cnt <= pix_cnt + 3'd1;
                    if (pix_cnt == 3'd7) begin
                        st <= (part == last_part) ? ST_CODE_REQ : ST_ROM_NEXT;
                    end
                end
                ST_ROM_NEXT: begin
                    rom.half <= ~rom.half;
                    if (part == 2'd1) begin
                        rom.addr[0] <= ~rom.addr[0];   // second 16 pixels of a 32x32 row
                    end
                    part   <= part + 2'd1;
                    rom.cs <= 1'b1;
                    st     <= ST_ROM_WAIT;
                end
                default: st <= ST_IDLE;
            endcase
            // last visible pixel is written at this edge
            if (lbuf.wr && lbuf.addr == bus_types_pkg::buf_addr_t'(`SCROLL_LINE_LAST)) begin
                lbuf.wr    <= 1'b0;
                done       <= 1'b1;
                vram.cs    <= 1'b0;
                rom.cs     <= 1'b0;
                map_enable <= 1'b0;
                st         <= ST_IDLE;
            end
            if (stop) begin
                done       <= 1'b1;
                vram.cs    <= 1'b0;
                rom.cs     <= 1'b0;
                map_enable <= 1'b0;
                lbuf.wr    <= 1'b0;
                st         <= ST_IDLE;
            end
        end
    end

endmodule

`default_nettype wire

/* source/scroll_layer.sv */
`timescale 1ns/100ps
`default_nettype none

module scroll_layer (
    input  wire                                clk,
    input  wire                                rst,
    input  wire scroll_types_pkg::layer_ctrl_t ctrl,
    input  wire scroll_types_pkg::bank_ctrl_t  bank,
    input  wire logic [8:0]                    vrender,
    input  wire                                start,
    input  wire                                stop,
    output logic                               done,
    output bus_types_pkg::vram_req_t           vram,
    input  wire logic [15:0]                   vram_data,
    input  wire                                vram_ok,
    output bus_types_pkg::rom_req_t            rom,
    input  wire logic [31:0]                   rom_data,
    input  wire                                rom_ok,
    input  wire bus_types_pkg::buf_addr_t      rd_addr,
    output scroll_types_pkg::pixel_t           rd_pixel
);

    logic                      map_enable;
    scroll_types_pkg::layer_t  map_layer;
    logic [3:0]                map_offset;
    logic [3:0]                map_mask;
    logic                      map_unmapped;
    bus_types_pkg::buf_write_t lbuf;

    tilemap_fetcher tilemap_fetcher_i (
        .clk          (clk),
        .rst          (rst),
        .ctrl         (ctrl),
        .vrender      (vrender),
        .start        (start),
        .stop         (stop),
        .done         (done),
        .vram         (vram),
        .vram_data    (vram_data),
        .vram_ok      (vram_ok),
        .rom          (rom),
        .rom_data     (rom_data),
        .rom_ok       (rom_ok),
        .map_enable   (map_enable),
        .map_layer    (map_layer),
        .map_offset   (map_offset),
        .map_mask     (map_mask),
        .map_unmapped (map_unmapped),
        .lbuf         (lbuf)
    );

    gfx_bank_mapper gfx_bank_mapper_i (
        .clk      (clk),
        .rst      (rst),
        .bank     (bank),
        .enable   (map_enable),
        .layer    (map_layer),
        .cin      (vram_data[15:6]),   // code bits seen by the mapper
        .offset   (map_offset),
        .mask     (map_mask),
        .unmapped (map_unmapped)
    );

    line_buffer line_buffer_i (
        .clk      (clk),
        .wr_port  (lbuf),
        .rd_addr  (rd_addr),
        .rd_pixel (rd_pixel)
    );

endmodule

`default_nettype wire

/* bench/scroll_layer_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "scroll_settings.svh"

module scroll_layer_tb;

    typedef struct packed {
        scroll_types_pkg::tile_size_t size;
        logic [15:0] hpos;
        logic [15:0] vpos;
        logic [8:0]  vrender;
        logic        row_en;
        logic [5:0]  game;
        logic [15:0] offset;
        logic [15:0] mask;
    } line_case_t;

    localparam int NUM_CASES = 7;

    // code limits per game, columns are layers 1 to 3
    localparam logic [9:0] LIMITS [4][3] = '{
        '{10'h3ff, 10'h3ff, 10'h3ff},
        '{10'h1ff, 10'h2ff, 10'h0ff},
        '{10'h0ff, 10'h17f, 10'h07f},
        '{10'h2ff, 10'h1ff, 10'h13f}
    };

    logic                          clk;
    logic                          rst;
    scroll_types_pkg::layer_ctrl_t ctrl;
    scroll_types_pkg::bank_ctrl_t  bank;
    logic [8:0]                    vrender;
    logic                          start;
    logic                          stop;
    logic                          done;
    bus_types_pkg::vram_req_t      vram;
    logic [15:0]                   vram_data;
    logic                          vram_ok;
    bus_types_pkg::rom_req_t       rom;
    logic [31:0]                   rom_data;
    logic                          rom_ok;
    bus_types_pkg::buf_addr_t      rd_addr;
    scroll_types_pkg::pixel_t      rd_pixel;

    logic [15:0]              vram_mem [2**`SCROLL_VRAM_AW];
    bus_types_pkg::rom_addr_t rom_seen [$];   // ROM addresses in request order
    line_case_t               cases [NUM_CASES];
    logic [31:0]              lfsr_state = 32'h4814_3c2b;
    logic                     vram_armed;
    logic [1:0]               vram_left;
    logic                     rom_armed;
    logic [1:0]               rom_left;

    scroll_layer scroll_layer_i (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .bank      (bank),
        .vrender   (vrender),
        .start     (start),
        .stop      (stop),
        .done      (done),
        .vram      (vram),
        .vram_data (vram_data),
        .vram_ok   (vram_ok),
        .rom       (rom),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .rd_addr   (rd_addr),
        .rd_pixel  (rd_pixel)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////
    // helpers

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_take(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] rom_word(input bus_types_pkg::rom_addr_t a, input logic half);
        logic [31:0] v;
        v = {11'd0, a, half} * 32'h9e37_79b1;
        return v ^ {v[15:0], v[31:16]};
    endfunction

    // tile under column x on line v, as the mapper and ROM should see it
    function automatic void tile_lookup(
        input  logic [10:0]                  x,
        input  logic [10:0]                  v,
        output bus_types_pkg::rom_addr_t     ra,
        output logic                         half,
        output scroll_types_pkg::tile_attr_t at,
        output logic                         um
    );
        logic [11:0]               scan;
        logic [1:0]                lay;
        logic [1:0]                part;
        logic [19:0]               pre;
        bus_types_pkg::vram_addr_t ta;
        logic [15:0]               code;
        case (ctrl.size)
            scroll_types_pkg::size_8: begin
                lay  = 2'd0;
                scan = {v[8], x[8:3], v[7:3]};
            end
            scroll_types_pkg::size_16: begin
                lay  = 2'd1;
                scan = {v[9:8], x[9:4], v[7:4]};
            end
            default: begin
                lay  = 2'd2;
                scan = {v[10:8], x[10:5], v[7:5]};
            end
        endcase
        ta   = {ctrl.vram_base[9:1], 8'd0} + {4'd0, scan, 1'b0};
        code = vram_mem[ta];
        at   = vram_mem[ta + 17'd1];
        part = (lay == 2'd0) ? 2'd0 : (lay == 2'd1) ? {1'b0, x[3]} : x[4:3];
        case (lay)
            2'd0:    pre = {1'b0, code, v[2:0] ^ {3{at.vflip}}};
            2'd1:    pre = {code, v[3:0] ^ {4{at.vflip}}};
            default: pre = {code[13:0], v[4:0] ^ {5{at.vflip}}, at.hflip ^ part[1]};
        endcase
        half = at.hflip ^ part[0];
        ra   = (pre & {bank.bank_mask[lay*4 +: 4], 16'hffff})
               | {bank.bank_offset[lay*4 +: 4], 16'h0};
        um   = (bank.game >= 6'(`SCROLL_NUM_GAMES))
               || (code[15:6] > LIMITS[bank.game[1:0]][lay]);
    endfunction

    function automatic scroll_types_pkg::pixel_t expect_pixel(
        input logic [10:0] x,
        input logic [10:0] v
    );
        bus_types_pkg::rom_addr_t     ra;
        logic                         half;
        scroll_types_pkg::tile_attr_t at;
        logic                         um;
        logic [31:0]                  w;
        int                           i;
        scroll_types_pkg::pixel_t     p;
        tile_lookup(x, v, ra, half, at, um);
        w = rom_word(ra, half);
        i = int'(x[2:0]);
        p.group  = at.group;
        p.pal    = at.pal;
        if (um) begin
            p.colour = 4'hf;
        end else if (at.hflip) begin
            p.colour = {w[24+i], w[16+i], w[8+i], w[i]};   // right to left
        end else begin
            p.colour = {w[31-i], w[23-i], w[15-i], w[7-i]};
        end
        return p;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_pixel(input string name, input scroll_types_pkg::pixel_t got,
                               input scroll_types_pkg::pixel_t exp);
        if (got !== exp) begin
            fail_run($sformatf("error %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_rom(input string name, input bus_types_pkg::rom_addr_t got,
                             input bus_types_pkg::rom_addr_t exp);
        if (got !== exp) begin
            fail_run($sformatf("error %s: got %h, expected %h", name, got, exp));
        end
    endtask

    //////////////////////////////
    // VRAM and ROM models

    // one process, so the latencies draw from the LFSR in a fixed order
    always begin
        @(posedge clk);
        #1;
        vram_ok = 1'b0;
        if (!vram.cs) begin
            vram_armed = 1'b0;
        end else begin
            if (!vram_armed) begin
                vram_armed = 1'b1;
                vram_left  = 2'(lfsr_take(2));
            end
            if (vram_left == 2'd0) begin
                vram_ok    = 1'b1;
                vram_data  = vram_mem[vram.addr];
                vram_armed = 1'b0;
            end else begin
                vram_left = vram_left - 2'd1;
            end
        end
        rom_ok = 1'b0;
        if (!rom.cs) begin
            rom_armed = 1'b0;
        end else begin
            if (!rom_armed) begin
                rom_armed = 1'b1;
                rom_left  = 2'(lfsr_take(2));
            end
            if (rom_left == 2'd0) begin
                rom_ok    = 1'b1;
                rom_data  = rom_word(rom.addr, rom.half);
                rom_armed = 1'b0;
                rom_seen.push_back(rom.addr);
            end else begin
                rom_left = rom_left - 2'd1;
            end
        end
    end

    //////////////////////////////
    // line runs

    task automatic apply_case(input line_case_t c);
        ctrl.size        = c.size;
        ctrl.vram_base   = 16'h0046;
        ctrl.hpos        = c.hpos;
        ctrl.vpos        = c.vpos;
        ctrl.row_en      = c.row_en;
        ctrl.vram_row    = 17'h1_2345;
        bank.game        = c.game;
        bank.bank_offset = c.offset;
        bank.bank_mask   = c.mask;
        vrender          = c.vrender;
        rom_seen.delete();
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic wait_done(input int limit);
        int cycles;
        cycles = 0;
        while (!done) begin
            if (cycles == limit) begin
                fail_run("timeout: done never pulsed");
            end
            @(posedge clk);
            #1;
            cycles++;
        end
    endtask

    task automatic run_line(input line_case_t c);
        logic [15:0]                  h;
        logic [10:0]                  v;
        logic [10:0]                  hn0;
        bus_types_pkg::rom_addr_t     ra;
        logic                         half;
        scroll_types_pkg::tile_attr_t at;
        logic                         um;
        apply_case(c);
        wait_done(20000);
        h   = c.row_en ? vram_mem[ctrl.vram_row] : c.hpos;
        v   = c.vpos[10:0] + {2'b0, c.vrender};
        hn0 = h[10:0] & ~11'({c.size, 3'b000} - 1);   // tile width minus one
        for (int a = 0; a <= `SCROLL_LINE_LAST; a++) begin
            rd_addr = 9'(a);
            @(posedge clk);
            #1;
            check_pixel($sformatf("rd_pixel[%0d]", a), rd_pixel, expect_pixel(11'(h + a), v));
        end
        if (rom_seen.size() == 0) begin
            fail_run("no ROM read was seen during the line");
        end
        foreach (rom_seen[i]) begin
            tile_lookup(11'(hn0 + 8 * i), v, ra, half, at, um);
            check_rom("rom.addr", rom_seen[i], ra);
        end
    endtask

    initial begin
        int n;
        rst     = 1'b1;
        ctrl    = '0;
        bank    = '0;
        vrender = '0;
        start   = 1'b0;
        stop    = 1'b0;
        rd_addr = '0;
        vram_ok = 1'b0;
        rom_ok  = 1'b0;
        vram_data = '0;
        rom_data  = '0;
        vram_armed = 1'b0;
        rom_armed  = 1'b0;
        for (int a = 0; a < 2**`SCROLL_VRAM_AW; a++) begin
            vram_mem[a] = 16'(lfsr_take(16));
        end
        cases[0] = '{scroll_types_pkg::size_8,  16'h0000, 16'h0000, 9'd16,  1'b0, 6'd0,
                     16'h0000, 16'hffff};
        cases[1] = '{scroll_types_pkg::size_16, 16'h0105, 16'h0020, 9'd100, 1'b0, 6'd0,
                     16'h0000, 16'hffff};
        cases[2] = '{scroll_types_pkg::size_32, 16'h0213, 16'h0077, 9'd200, 1'b0, 6'd0,
                     16'h0000, 16'hffff};
        cases[3] = '{scroll_types_pkg::size_8,  16'h0003, 16'h0100, 9'd33,  1'b1, 6'd1,
                     16'h0321, 16'h0777};
        cases[4] = '{scroll_types_pkg::size_16, 16'h07fe, 16'h03f0, 9'd255, 1'b0, 6'd2,
                     16'h0450, 16'h0a5c};
        cases[5] = '{scroll_types_pkg::size_32, 16'h001f, 16'h0555, 9'd7,   1'b1, 6'd3,
                     16'h0f0f, 16'h0ff0};
        cases[6] = '{scroll_types_pkg::size_16, 16'h0009, 16'h0003, 9'd500, 1'b0, 6'd5,
                     16'h0123, 16'h0ccc};   // game out of table range

        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // idle with start low
        for (int c = 0; c < 50; c++) begin
            @(posedge clk);
            #1;
            if (vram.cs || rom.cs || done) begin
                fail_run("fetcher left idle without start");
            end
        end

        for (int i = 0; i < NUM_CASES; i++) begin
            run_line(cases[i]);
        end

        //////////////////////////////
        // stop in the middle of a line
        apply_case(cases[2]);
        for (int c = 0; c < 200; c++) begin
            @(posedge clk);
            #1;
            if (done) begin
                fail_run("line ended before stop was raised");
            end
        end
        stop = 1'b1;
        n = 0;
        while (!done) begin
            if (n == 2) begin
                fail_run("done did not follow stop within 2 cycles");
            end
            @(posedge clk);
            #1;
            n++;
        end
        stop = 1'b0;
        @(posedge clk);
        #1;
        run_line(cases[3]);

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+include
source/scroll_types_pkg.sv
source/bus_types_pkg.sv
source/gfx_bank_mapper.sv
source/line_buffer.sv
source/tilemap_fetcher.sv
source/scroll_layer.sv
bench/scroll_layer_tb.sv

/* run.sh */
#!/bin/sh
# build and run the scroll layer testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal --top-module scroll_layer_tb \
        -f build.f -o scroll_sim; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/scroll_sim)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Result: PASSED"; then
    exit 0
fi
exit 1
